// File: Bender.yml
package:
  name: temp_sensor

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/tempSensorPkg.sv
      - rtl/byteCmdIf.sv
      - rtl/transactionSequencer.sv
      - rtl/i2cBitEngine.sv
      - rtl/tempCapture.sv
      - rtl/tempSensorTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/sensorModel.sv
      - tests/tempSensorTb.sv

// File: filelist.f
+incdir+rtl
rtl/tempSensorPkg.sv
rtl/byteCmdIf.sv
rtl/transactionSequencer.sv
rtl/i2cBitEngine.sv
rtl/tempCapture.sv
rtl/tempSensorTop.sv
tests/sensorModel.sv
tests/tempSensorTb.sv

// File: rtl/byteCmdIf.sv
`timescale 1ns/100ps

interface byteCmdIf import tempSensorPkg::*; ();

    logic       cmdStrobe;
    cmdKind_e   kind;
    i2cByte_u   txByte;
    logic       ackOut;
    logic       done;
    logic [7:0] rxByte;
    logic       ackIn;

    modport seqPort (
        output cmdStrobe, kind, txByte, ackOut,
        input  done, ackIn
    );

    modport enginePort (
        input  cmdStrobe, kind, txByte, ackOut,
        output done, ackIn, rxByte
    );

    // Capture only listens
    modport capturePort (
        input kind, ackOut, done, rxByte
    );

endinterface

// File: rtl/i2cBitEngine.sv
`timescale 1ns/100ps
`include "tempSensor_consts.svh"

module i2cBitEngine import tempSensorPkg::*; (
    input  logic            FSM_Clk,
    input  logic            rst,
    byteCmdIf.enginePort    cmd,
    input  logic            sdaIn,
    output logic            scl,
    output logic            sdaDriveLow
);

    localparam int PHASE_W = $clog2(`BIT_PHASES);
    localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`BIT_PHASES - 1);
    localparam logic [3:0] ACK_BIT = 4'd8;

    logic               busy;
    logic [PHASE_W-1:0] phaseCnt;
    logic [3:0]         bitCnt;
    logic [7:0]         shiftReg;
    logic               sclNow;
    logic               sdaNow;
    logic               sclHold;
    logic               sdaHold;
    logic               lastCycle;
    logic               isByte;

    assign isByte = (cmd.kind == writeByte) || (cmd.kind == readByte);

    // Bus levels for the current cycle of the operation
    always_comb begin
        sclNow    = 1'b1;
        sdaNow    = 1'b0;
        lastCycle = 1'b0;
        case (cmd.kind)
            startCond: begin
                // SDA falls while SCL is high, then SCL drops
                sclNow    = (phaseCnt == PHASE_W'(0));
                sdaNow    = 1'b1;
                lastCycle = (phaseCnt == PHASE_W'(1));
            end
            stopCond: begin
                sclNow    = (phaseCnt != PHASE_W'(0));
                sdaNow    = (phaseCnt != PHASE_W'(2));
                lastCycle = (phaseCnt == PHASE_W'(2));
            end
            default: begin
                sclNow    = (phaseCnt == PHASE_W'(1)) || (phaseCnt == PHASE_W'(2));
                lastCycle = (bitCnt == ACK_BIT) && (phaseCnt == PHASE_LAST);
                if (bitCnt == ACK_BIT) begin
                    sdaNow = (cmd.kind == readByte) && cmd.ackOut;
                end else begin
                    sdaNow = (cmd.kind == writeByte) && !shiftReg[7];
                end
            end
        endcase
    end

    assign cmd.done    = busy && lastCycle;
    assign cmd.rxByte  = shiftReg;
    assign scl         = busy ? sclNow : sclHold;
    assign sdaDriveLow = busy ? sdaNow : sdaHold;

    // Bus keeps its last level between operations
    always_ff @(posedge FSM_Clk) begin
        if (rst) begin
            sclHold <= 1'b1;
            sdaHold <= 1'b0;
        end else if (busy) begin
            sclHold <= sclNow;
            sdaHold <= sdaNow;
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (rst) begin
            busy     <= 1'b0;
            phaseCnt <= '0;
            bitCnt   <= 4'd0;
        end else if (!busy) begin
            if (cmd.cmdStrobe) begin
                busy     <= 1'b1;
                phaseCnt <= '0;
                bitCnt   <= 4'd0;
            end
        end else if (lastCycle) begin
            busy <= 1'b0;
        end else if (phaseCnt == PHASE_LAST) begin
            phaseCnt <= '0;
            bitCnt   <= bitCnt + 4'd1;
        end else begin
            phaseCnt <= phaseCnt + PHASE_W'(1);
        end
    end

    // Data path: load, shift out on write, shift in on read
    always_ff @(posedge FSM_Clk) begin
        if (!busy && cmd.cmdStrobe) begin
            shiftReg <= cmd.txByte.raw;
        end else if (busy && isByte && bitCnt != ACK_BIT) begin
            if (cmd.kind == readByte && phaseCnt == PHASE_W'(2)) begin
                shiftReg <= {shiftReg[6:0], sdaIn};
            end else if (cmd.kind == writeByte && phaseCnt == PHASE_LAST) begin
                shiftReg <= {shiftReg[6:0], 1'b0};
            end
        end
    end

    // Ninth bit of a write, 0 is ACK
    always_ff @(posedge FSM_Clk) begin
        if (busy && cmd.kind == writeByte && bitCnt == ACK_BIT &&
            phaseCnt == PHASE_W'(2)) begin
            cmd.ackIn <= sdaIn;
        end
    end

endmodule

// File: rtl/tempCapture.sv
`timescale 1ns/100ps
`include "tempSensor_consts.svh"

module tempCapture import tempSensorPkg::*; (
    input  logic                  FSM_Clk,
    input  logic                  rst,
    byteCmdIf.capturePort         cmd,
    output logic [`TEMP_BITS-1:0] temperature,
    output logic                  tempValid
);

    logic [7:0]  msbByte;
    logic [15:0] rawWord;
    logic        readDone;

    assign readDone = cmd.done && (cmd.kind == readByte);
    assign rawWord  = {msbByte, cmd.rxByte};

    // Acked byte is the MSB
    always_ff @(posedge FSM_Clk) begin
        if (readDone && cmd.ackOut) begin
            msbByte <= cmd.rxByte;
        end
    end

    always_ff @(posedge FSM_Clk) begin
        if (rst) begin
            temperature <= '0;
            tempValid   <= 1'b0;
        end else begin
            tempValid <= 1'b0;
            if (readDone && !cmd.ackOut) begin
                // Low three bits are flags
                temperature <= rawWord[15 -: `TEMP_BITS];
                tempValid   <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/tempSensorPkg.sv
package tempSensorPkg;

    // Byte-level bus operations
    typedef enum logic [1:0] {
        startCond = 2'd0,
        writeByte = 2'd1,
        readByte  = 2'd2,
        stopCond  = 2'd3
    } cmdKind_e;

    // One bus byte, either an address frame or plain data
    typedef union packed {
        struct packed {
            logic [6:0] addr;
            logic       rw;
        } frame;
        logic [7:0] raw;
    } i2cByte_u;

endpackage

// File: rtl/tempSensorTop.sv
`timescale 1ns/100ps
`include "tempSensor_consts.svh"

module tempSensorTop (
    input  logic                  FSM_Clk,
    input  logic                  rst,
    input  logic                  start,
    input  logic                  sdaIn,
    output logic                  scl,
    output logic                  sdaDriveLow,
    output logic                  tempValid,
    output logic                  ackError,
    output logic [`TEMP_BITS-1:0] temperature
);

    byteCmdIf cmdBus ();

    transactionSequencer sequencer_inst (
        .FSM_Clk  (FSM_Clk),
        .rst      (rst),
        .start    (start),
        .cmd      (cmdBus.seqPort),
        .ackError (ackError)
    );

    i2cBitEngine engine_inst (
        .FSM_Clk     (FSM_Clk),
        .rst         (rst),
        .cmd         (cmdBus.enginePort),
        .sdaIn       (sdaIn),
        .scl         (scl),
        .sdaDriveLow (sdaDriveLow)
    );

    tempCapture capture_inst (
        .FSM_Clk     (FSM_Clk),
        .rst         (rst),
        .cmd         (cmdBus.capturePort),
        .temperature (temperature),
        .tempValid   (tempValid)
    );

endmodule

// File: rtl/tempSensor_consts.svh
`ifndef TEMPSENSOR_CONSTS_SVH
`define TEMPSENSOR_CONSTS_SVH

// 7-bit bus address, A0 and A1 tied low
`define SENSOR_ADDR 7'h48

// Temperature MSB register
`define TEMP_REG_PTR 8'h00

// FSM_Clk cycles per bus bit
`define BIT_PHASES 4

// Upper bits of the 16-bit reading
`define TEMP_BITS 13

`endif

// File: rtl/transactionSequencer.sv
`timescale 1ns/100ps
`include "tempSensor_consts.svh"

module transactionSequencer import tempSensorPkg::*; (
    input  logic            FSM_Clk,
    input  logic            rst,
    input  logic            start,
    byteCmdIf.seqPort       cmd,
    output logic            ackError
);

    // Command list positions
    localparam logic [3:0] STEP_FIRST = 4'd0;
    localparam logic [3:0] STEP_LAST  = 4'd8;

    logic       startPrev;
    logic       startRise;
    logic       running;
    logic [3:0] step;

    assign startRise = start & ~startPrev;

    // Command for the current step, steady until done
    always_comb begin
        cmd.kind       = stopCond;
        cmd.txByte.raw = 8'h00;
        cmd.ackOut     = 1'b0;
        case (step)
            4'd0: begin
                cmd.kind = startCond;
            end
            4'd1: begin
                cmd.kind              = writeByte;
                cmd.txByte.frame.addr = `SENSOR_ADDR;
                cmd.txByte.frame.rw   = 1'b0;
            end
            4'd2: begin
                cmd.kind       = writeByte;
                cmd.txByte.raw = `TEMP_REG_PTR;
            end
            4'd3: begin
                cmd.kind = stopCond;
            end
            4'd4: begin
                cmd.kind = startCond;
            end
            4'd5: begin
                cmd.kind              = writeByte;
                cmd.txByte.frame.addr = `SENSOR_ADDR;
                cmd.txByte.frame.rw   = 1'b1;
            end
            // MSB, master acknowledges
            4'd6: begin
                cmd.kind   = readByte;
                cmd.ackOut = 1'b1;
            end
            // LSB, master NACKs to end the read
            4'd7: begin
                cmd.kind   = readByte;
                cmd.ackOut = 1'b0;
            end
            default: begin
                cmd.kind = stopCond;
            end
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (rst) begin
            startPrev     <= 1'b0;
            running       <= 1'b0;
            step          <= STEP_FIRST;
            cmd.cmdStrobe <= 1'b0;
            ackError      <= 1'b0;
        end else begin
            startPrev     <= start;
            cmd.cmdStrobe <= 1'b0;
            if (!running) begin
                if (startRise) begin
                    running       <= 1'b1;
                    step          <= STEP_FIRST;
                    ackError      <= 1'b0;
                    cmd.cmdStrobe <= 1'b1;
                end
            end else if (cmd.done) begin
                if (step == STEP_LAST) begin
                    running <= 1'b0;
                end else if (cmd.kind == writeByte && cmd.ackIn) begin
                    // Sensor NACK, close the bus
                    ackError      <= 1'b1;
                    step          <= STEP_LAST;
                    cmd.cmdStrobe <= 1'b1;
                end else begin
                    step          <= step + 4'd1;
                    cmd.cmdStrobe <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/sensorModel.sv
`timescale 1ns/100ps

module sensorModel (
    input  logic        FSM_Clk,
    input  logic        scl,
    input  logic        sda,
    input  logic        nackAddr,
    input  logic [15:0] readWord,
    output logic        pullLow,
    output logic [23:0] rxLog,
    output logic [1:0]  masterAcks,
    output int          byteCount,
    output int          startCount,
    output int          stopCount
);

    logic        sclPrev = 1'b1;
    logic        sdaPrev = 1'b1;
    logic        active = 1'b0;
    logic        sending = 1'b0;
    logic        addrPhase = 1'b0;
    logic        readMode = 1'b0;
    logic [3:0]  bitIdx = 4'd0;
    logic [7:0]  shiftIn = 8'h00;
    logic [15:0] txShift = 16'h0000;

    initial begin
        pullLow    <= 1'b0;
        rxLog      = '0;
        masterAcks = '0;
        byteCount  = 0;
        startCount = 0;
        stopCount  = 0;
    end

    // Bus sampled mid-cycle away from the DUT's clock edge
    always @(negedge FSM_Clk) begin
        if (scl === 1'b1 && sclPrev === 1'b1 && sdaPrev === 1'b1 && sda === 1'b0) begin
            active     = 1'b1;
            sending    = 1'b0;
            addrPhase  = 1'b1;
            bitIdx     = 4'd0;
            startCount = startCount + 1;
        end else if (active && scl === 1'b1 && sclPrev === 1'b1 &&
                     sdaPrev === 1'b0 && sda === 1'b1) begin
            active    = 1'b0;
            stopCount = stopCount + 1;
        end else if (active && sclPrev === 1'b0 && scl === 1'b1) begin
            bitIdx = bitIdx + 4'd1;
            if (!sending) begin
                shiftIn = {shiftIn[6:0], sda};
            end else if (bitIdx == 4'd9) begin
                masterAcks = {masterAcks[0], !sda};
            end
        end else if (active && sclPrev === 1'b1 && scl === 1'b0 && bitIdx != 4'd0) begin
            if (bitIdx == 4'd8 && !sending) begin
                rxLog     = {rxLog[15:0], shiftIn};
                byteCount = byteCount + 1;
                readMode  = shiftIn[0];
                pullLow   <= !(addrPhase && nackAddr);
            end else if (bitIdx == 4'd9) begin
                // A read address opens the data word after its ACK
                if (!sending && addrPhase && readMode && !nackAddr) begin
                    sending = 1'b1;
                    txShift = readWord;
                end else if (sending && !masterAcks[0]) begin
                    sending = 1'b0;
                end
                bitIdx    = 4'd0;
                addrPhase = 1'b0;
            end
            if (sending && bitIdx == 4'd8) begin
                pullLow <= 1'b0;
            end else if (sending) begin
                pullLow <= !txShift[15];
                txShift = {txShift[14:0], 1'b0};
            end else if (bitIdx == 4'd0) begin
                pullLow <= 1'b0;
            end
        end
        sclPrev = scl;
        sdaPrev = sda;
    end

endmodule

// File: tests/tempSensorTb.sv
`timescale 1ns/100ps
`include "tempSensor_consts.svh"

module tempSensorTb;

    localparam int SEQ_CYCLES     = 5 * 9 * `BIT_PHASES + 2 * 2 + 2 * 3 + 9;
    localparam int IDLE_CYCLES    = 40;
    localparam int TIMEOUT_CYCLES = 4 * (SEQ_CYCLES + IDLE_CYCLES + 10) + 400;

    logic                  FSM_Clk;
    logic                  rst;
    logic                  start;
    logic                  sda;
    logic                  scl;
    logic                  sdaDriveLow;
    logic                  tempValid;
    logic                  ackError;
    logic [`TEMP_BITS-1:0] temperature;
    logic                  modelPullLow;
    logic                  modelNack;
    logic [15:0]           modelWord;
    logic [23:0]           rxLog;
    logic [1:0]            masterAcks;
    int                    byteCount;
    int                    startCount;
    int                    stopCount;
    int                    validCount = 0;
    int                    sclEdges = 0;
    int                    cycleCount = 0;
    logic                  sclLast;
    logic [31:0]           lcgState;
    logic [`TEMP_BITS-1:0] lastTemp;

    // Open-drain SDA wire
    assign sda = !(sdaDriveLow || modelPullLow);

    tempSensorTop tempSensorTop_inst (
        .FSM_Clk     (FSM_Clk),
        .rst         (rst),
        .start       (start),
        .sdaIn       (sda),
        .scl         (scl),
        .sdaDriveLow (sdaDriveLow),
        .tempValid   (tempValid),
        .ackError    (ackError),
        .temperature (temperature)
    );

    sensorModel model_inst (
        .FSM_Clk    (FSM_Clk),
        .scl        (scl),
        .sda        (sda),
        .nackAddr   (modelNack),
        .readWord   (modelWord),
        .pullLow    (modelPullLow),
        .rxLog      (rxLog),
        .masterAcks (masterAcks),
        .byteCount  (byteCount),
        .startCount (startCount),
        .stopCount  (stopCount)
    );

    always #20 FSM_Clk = ~FSM_Clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic expectEqual(input string testName, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Fail %s: expected %0h, actual %0h", testName, expected, actual);
            $display("Test failed");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Counts pulses and SCL edges and limits the run
    always @(negedge FSM_Clk) begin
        cycleCount = cycleCount + 1;
        if (tempValid === 1'b1) begin
            validCount = validCount + 1;
        end
        if (scl !== sclLast) begin
            sclEdges = sclEdges + 1;
        end
        sclLast = scl;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: sequences did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Full read sequence where nack makes the sensor refuse its address
    task automatic runSequence(input string testName, input logic nack);
        int                    starts;
        int                    stops;
        int                    bytes;
        int                    valids;
        int                    edges;
        logic [15:0]           word;
        starts   = startCount;
        stops    = stopCount;
        bytes    = byteCount;
        valids   = validCount;
        lcgState = nextRandom(lcgState);
        word     = lcgState[31:16];
        @(posedge FSM_Clk);
        modelNack <= nack;
        modelWord <= word;
        start     <= 1'b1;
        if (nack) begin
            while (ackError !== 1'b1) @(negedge FSM_Clk);
            while (stopCount < stops + 1) @(negedge FSM_Clk);
            expectEqual({testName, " address byte"}, 32'h90, rxLog[7:0]);
            expectEqual({testName, " byte count"}, bytes + 1, byteCount);
            expectEqual({testName, " start count"}, starts + 1, startCount);
        end else begin
            while (tempValid !== 1'b1) @(negedge FSM_Clk);
            expectEqual({testName, " temperature"}, word[15:3], temperature);
            lastTemp = word[15:3];
            expectEqual({testName, " ackError"}, 0, ackError);
            expectEqual({testName, " master acks"}, 2'b10, masterAcks);
            while (stopCount < stops + 2) @(negedge FSM_Clk);
            expectEqual({testName, " bus bytes"}, 24'h900091, rxLog);
            expectEqual({testName, " byte count"}, bytes + 3, byteCount);
            expectEqual({testName, " start count"}, starts + 2, startCount);
        end
        // Bus stays quiet while start is held high
        edges = sclEdges;
        repeat (IDLE_CYCLES) @(negedge FSM_Clk);
        expectEqual({testName, " scl quiet"}, edges, sclEdges);
        expectEqual({testName, " stop count"}, stops + (nack ? 1 : 2), stopCount);
        expectEqual({testName, " valid pulses"}, valids + (nack ? 0 : 1), validCount);
        if (nack) begin
            expectEqual({testName, " ackError"}, 1, ackError);
            expectEqual({testName, " temperature held"}, lastTemp, temperature);
        end
        @(posedge FSM_Clk);
        start <= 1'b0;
        repeat (3) @(posedge FSM_Clk);
    endtask

    initial begin
        FSM_Clk   = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        modelNack = 1'b0;
        modelWord = 16'h0000;
        lcgState  = 32'd56;
        lastTemp  = '0;
        for (int i = 0; i < 4; i++) begin
            @(posedge FSM_Clk);
            if (i == 2) begin
                rst <= 1'b0;
            end
            @(negedge FSM_Clk);
            expectEqual("reset scl", 1, scl);
            expectEqual("reset sdaDriveLow", 0, sdaDriveLow);
            expectEqual("reset tempValid", 0, tempValid);
            expectEqual("reset ackError", 0, ackError);
            expectEqual("reset temperature", 0, temperature);
        end
        runSequence("first read", 1'b0);
        runSequence("second read", 1'b0);
        runSequence("sensor nack", 1'b1);
        runSequence("read after nack", 1'b0);
        $display("Test passed");
        $finish;
    end

endmodule
